// File: axi_rd_pkg.sv
// AXI read channel widths and the packed address / data channel structs
// shared by every block of the reorder unit

package axi_rd_pkg;

    ////////////////////
    // Channel widths
    ////////////////////

    // Byte address, full 32-bit space
    localparam int ADDR_W = 32;
    // Transaction ID, wide enough for the app ID and the tagged form
    localparam int ID_W   = 8;
    // Single-beat read data
    localparam int DATA_W = 32;
    // AXI RRESP code
    localparam int RESP_W = 2;

    ////////////////////
    // Channel payloads
    ////////////////////

    // Read address channel, 40 bits
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
    } ar_chan_t;

    // Read data channel, 42 bits
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [RESP_W-1:0] resp;
        logic [DATA_W-1:0] data;
    } r_chan_t;

endpackage

// File: rd_cpl_return.sv
// Return stage: one registered valid/ready slot toward the application

`timescale 1ns/1ps

module rd_cpl_return (
    input  logic                aclk,
    input  logic                aresetn,
    // Head of the tracker
    input  axi_rd_pkg::r_chan_t head,
    input  logic                head_valid,
    output logic                head_pop,
    // Application read data channel
    output axi_rd_pkg::r_chan_t app_r,
    output logic                app_rvalid,
    input  logic                app_rready
);

    // Stage takes the head when empty or being emptied this cycle
    logic load;

    assign load     = head_valid & (~app_rvalid | app_rready);
    // Popping the tracker on the loading edge
    assign head_pop = load;

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            app_rvalid <= 1'b0;
        end else if (load) begin
            app_rvalid <= 1'b1;
        end else if (app_rready) begin
            app_rvalid <= 1'b0;
        end
    end

    // Payload only moves with a load
    always_ff @(posedge aclk) begin
        if (load)
            app_r <= head;
    end

    // Stalled beat holds valid and payload until taken
    a_r_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        app_rvalid && !app_rready |=> app_rvalid && $stable(app_r));

endmodule

// File: rd_cpl_tracker.sv
// Completion tracker: per-tag slot state, stored IDs and completions,
// round-robin request pointer and in-order head pointer

`timescale 1ns/1ps

module rd_cpl_tracker #(
    parameter int                          OSTD_NUM = 4,
    parameter logic [axi_rd_pkg::ID_W-1:0] ID_MASK  = 8'h20
) (
    input  logic                        aclk,
    input  logic                        aresetn,
    // Reservation from the issue stage
    input  logic                        req_fire,
    input  logic [axi_rd_pkg::ID_W-1:0] req_slot,
    input  logic [axi_rd_pkg::ID_W-1:0] req_id,
    output logic [axi_rd_pkg::ID_W-1:0] next_slot,
    output logic                        slot_avlb,
    // Completions from both downstream paths, always accepted
    input  axi_rd_pkg::r_chan_t         io_r,
    input  logic                        io_rvalid,
    input  axi_rd_pkg::r_chan_t         blk_r,
    input  logic                        blk_rvalid,
    // Oldest request, toward the return stage
    output axi_rd_pkg::r_chan_t         head,
    output logic                        head_valid,
    input  logic                        head_pop,
    // Any slot in use
    output logic                        rd_pending
);

    import axi_rd_pkg::*;
    import rob_pkg::*;

    localparam int SLOT_W = (OSTD_NUM > 1) ? $clog2(OSTD_NUM) : 1;

    // Per-slot state and storage
    slot_state_t          state   [OSTD_NUM];
    logic [ID_W-1:0]      id_mem  [OSTD_NUM];
    cpl_entry_t           cpl_mem [OSTD_NUM];
    // Round-robin allocation and in-order return pointers
    logic [SLOT_W-1:0]    req_ptr;
    logic [SLOT_W-1:0]    head_ptr;
    // Completion IDs with the cache mask removed
    logic [ID_W-1:0]      io_slot;
    logic [ID_W-1:0]      blk_slot;

    assign io_slot  = io_r.id & ~ID_MASK;
    assign blk_slot = blk_r.id & ~ID_MASK;

    ////////////////////
    // Allocation
    ////////////////////

    // Next tag is the request pointer, usable only once its slot is free
    assign next_slot = ID_W'(req_ptr);
    assign slot_avlb = (state[req_ptr] == SLOT_FREE);

    always_comb begin
        rd_pending = 1'b0;
        for (int i = 0; i < OSTD_NUM; i++) begin
            if (state[i] != SLOT_FREE)
                rd_pending = 1'b1;
        end
    end

    ////////////////////
    // Slot state
    ////////////////////

    // Issue, completion and pop never hit the same slot in one cycle
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < OSTD_NUM; i++)
                state[i] <= SLOT_FREE;
        end else begin
            for (int i = 0; i < OSTD_NUM; i++) begin
                if (req_fire && req_slot[SLOT_W-1:0] == SLOT_W'(i))
                    state[i] <= SLOT_RSVD;
                // Both paths may land on different slots together
                if (io_rvalid && io_slot[SLOT_W-1:0] == SLOT_W'(i))
                    state[i] <= SLOT_RCVD;
                if (blk_rvalid && blk_slot[SLOT_W-1:0] == SLOT_W'(i))
                    state[i] <= SLOT_RCVD;
                if (head_pop && head_ptr == SLOT_W'(i))
                    state[i] <= SLOT_FREE;
            end
        end
    end

    // Original ID, kept for the return
    always_ff @(posedge aclk) begin
        if (req_fire)
            id_mem[req_slot[SLOT_W-1:0]] <= req_id;
    end

    // Completion payload per slot
    always_ff @(posedge aclk) begin
        if (io_rvalid)
            cpl_mem[io_slot[SLOT_W-1:0]] <= '{resp: io_r.resp, data: io_r.data};
        if (blk_rvalid)
            cpl_mem[blk_slot[SLOT_W-1:0]] <= '{resp: blk_r.resp, data: blk_r.data};
    end

    ////////////////////
    // Pointers
    ////////////////////

    // Power-of-two depth, so pointers wrap on overflow
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            req_ptr  <= '0;
            head_ptr <= '0;
        end else begin
            if (req_fire)
                req_ptr <= req_ptr + 1'b1;
            if (head_pop)
                head_ptr <= head_ptr + 1'b1;
        end
    end

    ////////////////////
    // Head
    ////////////////////

    // Valid the cycle after the head's completion lands
    assign head_valid = (state[head_ptr] == SLOT_RCVD);
    assign head.id    = id_mem[head_ptr];
    assign head.resp  = cpl_mem[head_ptr].resp;
    assign head.data  = cpl_mem[head_ptr].data;

    // Completions only for tags in range that are waiting for data
    a_io_cpl_rsvd: assert property (@(posedge aclk) disable iff (!aresetn)
        io_rvalid |-> (io_slot < OSTD_NUM) && state[io_slot[SLOT_W-1:0]] == SLOT_RSVD);
    a_blk_cpl_rsvd: assert property (@(posedge aclk) disable iff (!aresetn)
        blk_rvalid |-> (blk_slot < OSTD_NUM) && state[blk_slot[SLOT_W-1:0]] == SLOT_RSVD);

    for (genvar g = 0; g < OSTD_NUM; g++) begin : g_slot_chk
        a_no_ilgl: assert property (@(posedge aclk) disable iff (!aresetn)
            state[g] != SLOT_ILGL);
    end

endmodule

// File: rd_reorder_top.f
axi_rd_pkg.sv
rob_pkg.sv
rd_req_issue.sv
rd_cpl_tracker.sv
rd_cpl_return.sv
rd_reorder_top.sv
tb_rd_reorder.sv

// File: rd_reorder_top.sv
// Read completion reordering unit: issue stage, completion tracker
// and return stage wired together

`timescale 1ns/1ps

module rd_reorder_top #(
    parameter int                            OSTD_NUM = 4,
    parameter logic [axi_rd_pkg::ID_W-1:0]   ID_MASK  = 8'h20,
    parameter logic [axi_rd_pkg::ADDR_W-1:0] IO_BASE  = 32'h8000_0000
) (
    input  logic                 aclk,
    input  logic                 aresetn,
    // Application side
    input  axi_rd_pkg::ar_chan_t app_ar,
    input  logic                 app_arvalid,
    output logic                 app_arready,
    output axi_rd_pkg::r_chan_t  app_r,
    output logic                 app_rvalid,
    input  logic                 app_rready,
    // IO path
    output axi_rd_pkg::ar_chan_t io_ar,
    output logic                 io_arvalid,
    input  logic                 io_arready,
    input  axi_rd_pkg::r_chan_t  io_r,
    input  logic                 io_rvalid,
    output logic                 io_rready,
    // Block path
    output axi_rd_pkg::ar_chan_t blk_ar,
    output logic                 blk_arvalid,
    input  logic                 blk_arready,
    input  axi_rd_pkg::r_chan_t  blk_r,
    input  logic                 blk_rvalid,
    output logic                 blk_rready,
    // Status
    output logic                 rd_pending
);

    import axi_rd_pkg::*;

    // Issue to tracker
    logic            req_fire;
    logic [ID_W-1:0] req_slot;
    logic [ID_W-1:0] req_id;
    logic [ID_W-1:0] next_slot;
    logic            slot_avlb;
    // Tracker to return stage
    r_chan_t         head;
    logic            head_valid;
    logic            head_pop;

    // Completions always land in their slot
    assign io_rready  = 1'b1;
    assign blk_rready = 1'b1;

    rd_req_issue #(
        .ID_MASK (ID_MASK),
        .IO_BASE (IO_BASE)
    ) u_issue (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .app_ar      (app_ar),
        .app_arvalid (app_arvalid),
        .app_arready (app_arready),
        .io_ar       (io_ar),
        .io_arvalid  (io_arvalid),
        .io_arready  (io_arready),
        .blk_ar      (blk_ar),
        .blk_arvalid (blk_arvalid),
        .blk_arready (blk_arready),
        .next_slot   (next_slot),
        .slot_avlb   (slot_avlb),
        .req_fire    (req_fire),
        .req_slot    (req_slot),
        .req_id      (req_id)
    );

    rd_cpl_tracker #(
        .OSTD_NUM (OSTD_NUM),
        .ID_MASK  (ID_MASK)
    ) u_tracker (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .req_fire   (req_fire),
        .req_slot   (req_slot),
        .req_id     (req_id),
        .next_slot  (next_slot),
        .slot_avlb  (slot_avlb),
        .io_r       (io_r),
        .io_rvalid  (io_rvalid),
        .blk_r      (blk_r),
        .blk_rvalid (blk_rvalid),
        .head       (head),
        .head_valid (head_valid),
        .head_pop   (head_pop),
        .rd_pending (rd_pending)
    );

    rd_cpl_return u_return (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .head       (head),
        .head_valid (head_valid),
        .head_pop   (head_pop),
        .app_r      (app_r),
        .app_rvalid (app_rvalid),
        .app_rready (app_rready)
    );

endmodule

// File: rd_req_issue.sv
// Request issue stage with address decode, tag substitution and
// routing of application reads onto the IO or block path

`timescale 1ns/1ps

module rd_req_issue #(
    parameter logic [axi_rd_pkg::ID_W-1:0]   ID_MASK = 8'h20,
    parameter logic [axi_rd_pkg::ADDR_W-1:0] IO_BASE = 32'h8000_0000
) (
    input  logic                        aclk,
    input  logic                        aresetn,
    // Application read address channel
    input  axi_rd_pkg::ar_chan_t        app_ar,
    input  logic                        app_arvalid,
    output logic                        app_arready,
    // IO path read address channel
    output axi_rd_pkg::ar_chan_t        io_ar,
    output logic                        io_arvalid,
    input  logic                        io_arready,
    // Block path read address channel
    output axi_rd_pkg::ar_chan_t        blk_ar,
    output logic                        blk_arvalid,
    input  logic                        blk_arready,
    // Tag offered by the tracker
    input  logic [axi_rd_pkg::ID_W-1:0] next_slot,
    input  logic                        slot_avlb,
    // Reservation toward the tracker
    output logic                        req_fire,
    output logic [axi_rd_pkg::ID_W-1:0] req_slot,
    output logic [axi_rd_pkg::ID_W-1:0] req_id
);

    import axi_rd_pkg::*;

    // High when the request targets the IO window
    logic     is_io;
    // Ready of whichever path the address selects
    logic     path_ready;
    // Request with its ID replaced by the local tag
    ar_chan_t tagged_ar;

    ////////////////////
    // Decode
    ////////////////////

    assign is_io      = (app_ar.addr >= IO_BASE);
    assign path_ready = is_io ? io_arready : blk_arready;

    // Mask marks the tag as belonging to the data cache
    assign tagged_ar.addr = app_ar.addr;
    assign tagged_ar.id   = next_slot | ID_MASK;

    ////////////////////
    // Hand-off
    ////////////////////

    // No downstream valid without a free slot to land in
    assign io_arvalid  = app_arvalid & slot_avlb & is_io;
    assign blk_arvalid = app_arvalid & slot_avlb & ~is_io;

    // Unselected path sees an all-zero payload
    assign io_ar  = is_io ? tagged_ar : '0;
    assign blk_ar = is_io ? '0 : tagged_ar;

    // Blocked path stalls the whole stream so order is kept
    assign app_arready = slot_avlb & path_ready;

    // Reservation for the tracker
    assign req_fire = app_arvalid & app_arready;
    assign req_slot = next_slot;
    assign req_id   = app_ar.id;

    // A waiting downstream request keeps its slot offered until it is taken
    a_slot_held: assert property (@(posedge aclk) disable iff (!aresetn)
        ((io_arvalid && !io_arready) || (blk_arvalid && !blk_arready)) |=> slot_avlb);

endmodule

// File: rob_pkg.sv
// Tag-slot state encoding and the completion entry held per slot

package rob_pkg;

    ////////////////////
    // Slot state
    ////////////////////

    // Bit 0 is set on request issue, bit 1 on completion receipt
    typedef enum logic [1:0] {
        // Unused or already returned
        SLOT_FREE = 2'b00,
        // Request issued, waiting for data
        SLOT_RSVD = 2'b01,
        // Completion stored, waiting for its turn
        SLOT_RCVD = 2'b11,
        // Completion without a request, never reached
        SLOT_ILGL = 2'b10
    } slot_state_t;

    ////////////////////
    // Slot payload
    ////////////////////

    // Resp and data kept until the slot reaches the head, 34 bits
    typedef struct packed {
        logic [axi_rd_pkg::RESP_W-1:0] resp;
        logic [axi_rd_pkg::DATA_W-1:0] data;
    } cpl_entry_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Compile the reorder unit and its testbench with Verilator, run it,
# and decide the result from the simulation log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rd_reorder \
    -f rd_reorder_top.f -o sim_bin
# The log is searched below, so a non-zero exit here must not end the script
./obj_dir/sim_bin > sim.log 2>&1 || true
cat sim.log
grep -q "SIMULATION PASSED" sim.log

// File: tb_rd_reorder.sv
// Testbench for the read reorder unit with a request generator,
// out-of-order responders on both paths, an in-order model and checks

`timescale 1ns/1ps

module tb_rd_reorder;

    import axi_rd_pkg::*;

    // Same values as the DUT defaults
    localparam int                OSTD_NUM = 4;
    localparam logic [ID_W-1:0]   ID_MASK  = 8'h20;
    localparam logic [ADDR_W-1:0] IO_BASE  = 32'h8000_0000;
    // Cycle limit for every wait loop
    localparam int                TIMEOUT  = 2000;

    logic     aclk;
    logic     aresetn;
    ar_chan_t app_ar;
    logic     app_arvalid;
    logic     app_arready;
    r_chan_t  app_r;
    logic     app_rvalid;
    logic     app_rready;
    ar_chan_t io_ar;
    logic     io_arvalid;
    logic     io_arready;
    r_chan_t  io_r;
    logic     io_rvalid;
    logic     io_rready;
    ar_chan_t blk_ar;
    logic     blk_arvalid;
    logic     blk_arready;
    r_chan_t  blk_r;
    logic     blk_rvalid;
    logic     blk_rready;
    logic     rd_pending;

    // Requests waiting for an answer on each path with the tag in the id field
    ar_chan_t io_q[$];
    ar_chan_t blk_q[$];
    // Application requests in acceptance order
    ar_chan_t model_q[$];
    int       acc_cnt;
    int       ret_cnt;
    int       err_cnt;
    int       chk_cnt;
    int       test_cnt;
    int       test_fail;
    // Stimulus modes
    bit       ar_rand;
    bit       rr_rand;
    bit       cpl_hold;
    // Stalled beat seen on the previous edge
    logic     stall_prev;
    r_chan_t  held_r;

    rd_reorder_top dut (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .app_ar      (app_ar),
        .app_arvalid (app_arvalid),
        .app_arready (app_arready),
        .app_r       (app_r),
        .app_rvalid  (app_rvalid),
        .app_rready  (app_rready),
        .io_ar       (io_ar),
        .io_arvalid  (io_arvalid),
        .io_arready  (io_arready),
        .io_r        (io_r),
        .io_rvalid   (io_rvalid),
        .io_rready   (io_rready),
        .blk_ar      (blk_ar),
        .blk_arvalid (blk_arvalid),
        .blk_arready (blk_arready),
        .blk_r       (blk_r),
        .blk_rvalid  (blk_rvalid),
        .blk_rready  (blk_rready),
        .rd_pending  (rd_pending)
    );

    always #5 aclk = ~aclk;

    ////////////////////
    // Helpers
    ////////////////////

    // Memory contents seen by both paths
    function automatic logic [DATA_W-1:0] data_of(input logic [ADDR_W-1:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h6b3d_91c7;
    endfunction

    // Response beat for a tagged request with resp from the low address bits
    function automatic r_chan_t make_beat(input ar_chan_t req);
        r_chan_t beat;
        beat.id   = req.id;
        beat.resp = req.addr[1:0];
        beat.data = data_of(req.addr);
        return beat;
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %0h, expected %0h at %0t", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s at %0t", msg, $time);
        err_cnt++;
    endtask

    task automatic end_test(input string name, input int err_start);
        test_cnt++;
        if (err_cnt != err_start) begin
            test_fail++;
            $display("test %s: %0d errors", name, err_cnt - err_start);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // Random address on either side of the IO boundary, random ID
    task automatic drive_req();
        logic [ADDR_W-1:0] offs;
        offs = $urandom % IO_BASE;
        app_ar.addr = ($urandom % 2) ? IO_BASE + offs : offs;
        app_ar.id   = ID_W'($urandom);
        app_arvalid = 1'b1;
    endtask

    // Acceptance shows up in the monitor's count by the next falling edge
    task automatic wait_accept();
        int start;
        int waited;
        start  = acc_cnt;
        waited = 0;
        do begin
            @(negedge aclk);
            waited++;
        end while (acc_cnt == start && waited < TIMEOUT);
        if (acc_cnt == start)
            report_error("request was not accepted before the timeout");
        app_arvalid = 1'b0;
    endtask

    task automatic send_req(input int max_gap);
        repeat ($urandom % (max_gap + 1)) @(negedge aclk);
        drive_req();
        wait_accept();
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((rd_pending || model_q.size() != 0) && waited < TIMEOUT) begin
            @(negedge aclk);
            waited++;
        end
        if (rd_pending || model_q.size() != 0)
            report_error("outstanding reads did not drain before the timeout");
    endtask

    ////////////////////
    // Responders
    ////////////////////

    // Ready and completions change on the falling edge only
    always @(negedge aclk) begin
        int idx;
        io_arready  = ar_rand ? (($urandom % 4) != 0) : 1'b1;
        blk_arready = ar_rand ? (($urandom % 4) != 0) : 1'b1;
        app_rready  = rr_rand ? (($urandom % 2) != 0) : 1'b1;
        io_rvalid   = 1'b0;
        blk_rvalid  = 1'b0;
        // Random pick from the queue gives out-of-order answers
        if (aresetn && !cpl_hold) begin
            if (io_q.size() > 0 && ($urandom % 3) == 0) begin
                idx = $urandom % io_q.size();
                io_r = make_beat(io_q[idx]);
                io_q.delete(idx);
                io_rvalid = 1'b1;
            end
            if (blk_q.size() > 0 && ($urandom % 3) == 0) begin
                idx = $urandom % blk_q.size();
                blk_r = make_beat(blk_q[idx]);
                blk_q.delete(idx);
                blk_rvalid = 1'b1;
            end
        end
    end

    ////////////////////
    // Monitor
    ////////////////////

    always @(posedge aclk) begin
        ar_chan_t        exp_ar;
        logic [ID_W-1:0] exp_tag;
        if (!aresetn) begin
            stall_prev = 1'b0;
        end else begin
            // Tag is the acceptance count modulo depth with the mask
            if (app_arvalid && app_arready) begin
                exp_tag = ID_W'(acc_cnt % OSTD_NUM) | ID_MASK;
                if (app_ar.addr >= IO_BASE) begin
                    if (!(io_arvalid && io_arready) || blk_arvalid)
                        report_error("IO request not routed to the IO path alone");
                    check_eq("io_ar.addr", io_ar.addr, app_ar.addr);
                    check_eq("io_ar.id", io_ar.id, exp_tag);
                    io_q.push_back(io_ar);
                end else begin
                    if (!(blk_arvalid && blk_arready) || io_arvalid)
                        report_error("block request not routed to the block path alone");
                    check_eq("blk_ar.addr", blk_ar.addr, app_ar.addr);
                    check_eq("blk_ar.id", blk_ar.id, exp_tag);
                    blk_q.push_back(blk_ar);
                end
                model_q.push_back(app_ar);
                acc_cnt++;
            end else if ((io_arvalid && io_arready) || (blk_arvalid && blk_arready)) begin
                report_error("downstream request without an application handshake");
            end
            // Returns come back in acceptance order with the original ID
            if (app_rvalid && app_rready) begin
                if (model_q.size() == 0) begin
                    report_error("return beat with no outstanding request");
                end else begin
                    exp_ar = model_q.pop_front();
                    check_eq("app_r.id", app_r.id, exp_ar.id);
                    check_eq("app_r.data", app_r.data, data_of(exp_ar.addr));
                    check_eq("app_r.resp", app_r.resp, exp_ar.addr[1:0]);
                    ret_cnt++;
                end
            end
            if (stall_prev) begin
                check_eq("app_rvalid", app_rvalid, 1'b1);
                check_eq("app_r", app_r, held_r);
            end
            stall_prev = app_rvalid && !app_rready;
            held_r     = app_r;
        end
    end

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        int err_start;
        int acc_start;
        void'($urandom(32'h28e4));
        aclk        = 1'b0;
        aresetn     = 1'b0;
        app_ar      = '0;
        app_arvalid = 1'b0;
        app_rready  = 1'b1;
        io_arready  = 1'b1;
        blk_arready = 1'b1;
        io_r        = '0;
        io_rvalid   = 1'b0;
        blk_r       = '0;
        blk_rvalid  = 1'b0;
        ar_rand     = 1'b0;
        rr_rand     = 1'b0;
        cpl_hold    = 1'b0;
        stall_prev  = 1'b0;
        acc_cnt     = 0;
        ret_cnt     = 0;
        err_cnt     = 0;
        chk_cnt     = 0;
        test_cnt    = 0;
        test_fail   = 0;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        // Idle outputs right after reset
        err_start = err_cnt;
        @(posedge aclk);
        check_eq("app_rvalid", app_rvalid, 1'b0);
        check_eq("io_arvalid", io_arvalid, 1'b0);
        check_eq("blk_arvalid", blk_arvalid, 1'b0);
        check_eq("rd_pending", rd_pending, 1'b0);
        check_eq("app_arready", app_arready, 1'b1);
        // Completion inputs never push back
        check_eq("io_rready", io_rready, 1'b1);
        check_eq("blk_rready", blk_rready, 1'b1);
        @(negedge aclk);
        end_test("reset state", err_start);

        err_start = err_cnt;
        ar_rand = 1'b1;
        for (int i = 0; i < 30; i++)
            send_req(3);
        wait_drain();
        end_test("routing and tag substitution", err_start);

        err_start = err_cnt;
        for (int i = 0; i < 60; i++)
            send_req(1);
        wait_drain();
        end_test("in-order return", err_start);

        // Silent responders so allocation must stop at the depth
        err_start = err_cnt;
        ar_rand   = 1'b0;
        cpl_hold  = 1'b1;
        acc_start = acc_cnt;
        for (int i = 0; i < OSTD_NUM; i++)
            send_req(0);
        drive_req();
        repeat (20) begin
            @(posedge aclk);
            check_eq("app_arready", app_arready, 1'b0);
            check_eq("rd_pending", rd_pending, 1'b1);
        end
        @(negedge aclk);
        check_eq("accepted requests", acc_cnt - acc_start, OSTD_NUM);
        cpl_hold = 1'b0;
        wait_accept();
        for (int i = 0; i < 8; i++)
            send_req(1);
        wait_drain();
        end_test("outstanding limit", err_start);

        err_start = err_cnt;
        ar_rand = 1'b1;
        rr_rand = 1'b1;
        for (int i = 0; i < 60; i++)
            send_req(2);
        wait_drain();
        rr_rand = 1'b0;
        end_test("back-pressure", err_start);

        err_start = err_cnt;
        wait_drain();
        check_eq("rd_pending", rd_pending, 1'b0);
        check_eq("returns", ret_cnt, acc_cnt);
        check_eq("io queue size", io_q.size(), 0);
        check_eq("blk queue size", blk_q.size(), 0);
        end_test("drain", err_start);

        $display("tests %0d, failed %0d, checks %0d, errors %0d, requests %0d, returns %0d",
                 test_cnt, test_fail, chk_cnt, err_cnt, acc_cnt, ret_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
